// ==== testbench/issue_testdata.hex ====
// instruction word, commit flag, expected rd, expected value
// flag 0 marks a word that is acknowledged but must not commit
00500093 1 01 00000005 // addi x1, x0, 5
FFD00113 1 02 FFFFFFFD // addi x2, x0, -3
002081B3 1 03 00000002 // add x3, x1, x2
40118233 1 04 FFFFFFFD // sub x4, x3, x1
00100293 1 05 00000001
00200293 1 05 00000002 // younger write to x5
00528333 1 06 00000004 // add x6, x5, x5
800003B7 1 07 80000000 // lui x7, 0x80000
4043D413 1 08 F8000000 // srai x8, x7, 4
00708013 0 00 00000000 // addi x0, x1, 7
00102083 0 00 00000000 // lw, not in the ALU group
001004B3 1 09 00000005 // add x9, x0, x1
0043D513 1 0A 08000000 // srli x10, x7, 4
0013A5B3 1 0B 00000001 // slt x11, x7, x1
0013B633 1 0C 00000000 // sltu x12, x7, x1
FFF12693 1 0D 00000001 // slti x13, x2, -1
FFF13713 1 0E 00000001 // sltiu x14, x2, -1
FFF0C793 1 0F FFFFFFFA // xori x15, x1, -1
0070E833 1 10 80000005 // or x16, x1, x7
001178B3 1 11 00000005 // and x17, x2, x1
00109933 1 12 000000A0 // sll x18, x1, x1

// ==== list.f ====
hdl/rename_pkg.sv
hdl/inst_decode.sv
hdl/tag_regfile.sv
hdl/alu_execute.sv
hdl/reorder_buffer.sv
hdl/issue_core.sv
testbench/tb_issue_core.sv

// ==== Makefile ====
TOP := tb_issue_core

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== testbench/tb_issue_core.sv ====
`timescale 1ns/1ps

module tb_issue_core
    import rename_pkg::*;
();

    localparam int MAX_INST  = 64;
    localparam int COLS      = 4;     // word, flag, rd, value
    localparam int CLK_HALF  = 10;
    localparam int ACK_LIMIT = 100;

    logic   clk      = 1'b0;
    logic   rst      = 1'b1;
    logic   inst_req = 1'b0;
    inst_t  inst     = '0;
    logic   inst_ack;
    logic   commit_en;
    regnm_t commit_rd;
    data_t  commit_data;

    logic [31:0] tdata [MAX_INST*COLS];
    regnm_t      exp_rd   [MAX_INST];
    data_t       exp_data [MAX_INST];

    int n_inst = 0;
    int n_exp  = 0;
    int n_seen = 0;
    int errors = 0;
    int seed   = 90;
    bit loaded = 1'b0;

    issue_core u_dut (
        .clk, .rst, .inst_req, .inst, .inst_ack,
        .commit_en, .commit_rd, .commit_data
    );

    initial begin
        forever #CLK_HALF clk = ~clk;
    end

    // fills the table, then keeps only the entries with a commit for the checker
    task automatic load_testdata();
        for (int i = 0; i < MAX_INST*COLS; i++)
            tdata[i] = {16'hdead, 16'(i)};  // flag column of unused rows is > 1
        $readmemh("testbench/issue_testdata.hex", tdata);
        while (n_inst < MAX_INST && tdata[n_inst*COLS+1] <= 32'd1) begin
            if (tdata[n_inst*COLS+1] == 32'd1) begin
                exp_rd[n_exp]   = regnm_t'(tdata[n_inst*COLS+2]);
                exp_data[n_exp] = tdata[n_inst*COLS+3];
                n_exp++;
            end
            n_inst++;
        end
        if (n_inst == 0) begin
            $display("no instructions were read from the data file");
            errors++;
        end
        loaded = 1'b1;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (inst_ack !== 1'b0) begin
                $display("ERR inst_ack: got %h, expected %h before any request", inst_ack, 1'b0);
                errors++;
            end
            if (commit_en !== 1'b0) begin
                $display("ERR commit_en: got %h, expected %h before any request", commit_en, 1'b0);
                errors++;
            end
        end
    endtask

    // four-phase transfer of one word
    task automatic send_word(input inst_t word, output bit ok);
        int cnt;
        ok = 1'b1;
        @(negedge clk);
        inst     = word;
        inst_req = 1'b1;
        cnt      = 0;
        @(negedge clk);
        while (!inst_ack && cnt < ACK_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!inst_ack) begin
            $display("the DUT never acknowledged instruction word %h", word);
            errors++;
            ok = 1'b0;
        end
        inst_req = 1'b0;
        cnt      = 0;
        @(negedge clk);
        while (inst_ack && cnt < ACK_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (inst_ack) begin
            $display("the DUT kept inst_ack high after the request was dropped");
            errors++;
            ok = 1'b0;
        end
    endtask

    // commit pulse is stable between rising edges
    always @(negedge clk) begin
        if (!rst && commit_en) begin
            if (n_seen >= n_exp) begin
                $display("an extra commit to x%0d with data %h arrived after the expected list",
                         commit_rd, commit_data);
                errors++;
            end else begin
                if (commit_rd !== exp_rd[n_seen]) begin
                    $display("ERR commit_rd: got %h, expected %h (commit %0d)",
                             commit_rd, exp_rd[n_seen], n_seen);
                    errors++;
                end
                if (commit_data !== exp_data[n_seen]) begin
                    $display("ERR commit_data: got %h, expected %h (commit %0d)",
                             commit_data, exp_data[n_seen], n_seen);
                    errors++;
                end
            end
            n_seen++;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = 40 * n_inst + 200;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        bit ok;
        int gap;
        int cnt;
        load_testdata();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_quiet(4);
        ok = 1'b1;
        for (int i = 0; i < n_inst && ok; i++) begin
            send_word(tdata[i*COLS], ok);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
        end
        cnt = 0;
        while (n_seen < n_exp && cnt < ACK_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        repeat (20) @(negedge clk);  // late duplicates
        if (n_seen != n_exp) begin
            $display("the number of commits is wrong, %0d seen and %0d expected", n_seen, n_exp);
            errors++;
        end
        $display("summary: %0d instructions, %0d of %0d commits seen, %0d errors",
                 n_inst, n_seen, n_exp, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hdl/issue_core.sv ====
`timescale 1ns/1ps

module issue_core
    import rename_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   inst_req,
    input  inst_t  inst,
    output logic   inst_ack,
    output logic   commit_en,
    output regnm_t commit_rd,
    output data_t  commit_data
);

    logic    dec_valid;
    regnm_t  dec_rd;
    regnm_t  dec_rs1;
    regnm_t  dec_rs2;
    logic    dec_use_rs2;
    data_t   dec_imm;
    alu_op_t dec_op;
    logic    issue_take;

    data_t   rs1_data;
    data_t   rs2_data;
    tag_t    rs1_tag;
    tag_t    rs2_tag;

    logic    alloc_en;
    regnm_t  alloc_rd;
    tag_t    alloc_tag;

    logic    ex_en;
    alu_op_t ex_op;
    data_t   ex_a;
    data_t   ex_b;
    tag_t    ex_tag;

    logic    wb_en;
    tag_t    wb_tag;
    data_t   wb_data;
    tag_t    cm_tag;

    inst_decode u_decode (
        .clk, .rst, .inst_req, .inst, .inst_ack, .issue_take,
        .dec_valid, .dec_rd, .dec_rs1, .dec_rs2, .dec_use_rs2, .dec_imm, .dec_op
    );

    tag_regfile u_regfile (
        .clk, .rst, .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_data, .rs2_data, .rs1_tag, .rs2_tag,
        .alloc_en, .alloc_rd, .alloc_tag,
        .cm_en(commit_en), .cm_rd(commit_rd), .cm_tag, .cm_data(commit_data)
    );

    reorder_buffer u_rob (
        .clk, .rst, .dec_valid, .dec_rd, .dec_rs1, .dec_rs2, .dec_use_rs2, .dec_imm, .dec_op,
        .rs1_data, .rs2_data, .rs1_tag, .rs2_tag, .issue_take,
        .alloc_en, .alloc_rd, .alloc_tag,
        .ex_en, .ex_op, .ex_a, .ex_b, .ex_tag,
        .wb_en, .wb_tag, .wb_data,
        .cm_en(commit_en), .cm_rd(commit_rd), .cm_tag, .cm_data(commit_data)
    );

    alu_execute u_alu (
        .clk, .rst, .ex_en, .ex_op, .ex_a, .ex_b, .ex_tag,
        .wb_en, .wb_tag, .wb_data
    );

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    dec_valid,
    input  regnm_t  dec_rd,
    input  regnm_t  dec_rs1,
    input  regnm_t  dec_rs2,
    input  logic    dec_use_rs2,
    input  data_t   dec_imm,
    input  alu_op_t dec_op,
    input  data_t   rs1_data,
    input  data_t   rs2_data,
    input  tag_t    rs1_tag,
    input  tag_t    rs2_tag,
    output logic    issue_take,
    output logic    alloc_en,
    output regnm_t  alloc_rd,
    output tag_t    alloc_tag,
    output logic    ex_en,
    output alu_op_t ex_op,
    output data_t   ex_a,
    output data_t   ex_b,
    output tag_t    ex_tag,
    input  logic    wb_en,
    input  tag_t    wb_tag,
    input  data_t   wb_data,
    output logic    cm_en,
    output regnm_t  cm_rd,
    output tag_t    cm_tag,
    output data_t   cm_data
);

    // entries are indexed by their tag
    regnm_t               ent_rd   [1:ROB_DEPTH];
    data_t                ent_data [1:ROB_DEPTH];
    logic [ROB_DEPTH:1]   ent_busy;
    logic [ROB_DEPTH:1]   ent_done;
    tag_t                 head;
    tag_t                 tail;
    logic [TAG_W:0]       count;

    logic  src1_wait;
    logic  src2_wait;
    logic  a_ok;
    logic  b_ok;
    logic  full;
    data_t rs2_val;

    function automatic tag_t next_tag(input tag_t t);
        return (t == tag_t'(ROB_DEPTH)) ? tag_t'(1) : t + tag_t'(1);
    endfunction

    // operand resolution
    assign src1_wait = (dec_rs1 != '0) && (rs1_tag != TAG_NONE);
    assign src2_wait = (dec_rs2 != '0) && (rs2_tag != TAG_NONE);
    assign a_ok      = !src1_wait || ent_done[rs1_tag];
    assign b_ok      = !dec_use_rs2 || !src2_wait || ent_done[rs2_tag];
    assign ex_a      = src1_wait ? ent_data[rs1_tag] : rs1_data;
    assign rs2_val   = src2_wait ? ent_data[rs2_tag] : rs2_data;
    assign ex_b      = dec_use_rs2 ? rs2_val : dec_imm;

    assign full       = (count == ROB_DEPTH);
    assign issue_take = dec_valid && a_ok && b_ok && !full;

    assign alloc_en  = issue_take;
    assign alloc_rd  = dec_rd;
    assign alloc_tag = tail;
    assign ex_en     = issue_take;
    assign ex_op     = dec_op;
    assign ex_tag    = tail;

    // head retires once its result is in
    assign cm_en   = ent_busy[head] && ent_done[head];
    assign cm_rd   = ent_rd[head];
    assign cm_tag  = head;
    assign cm_data = ent_data[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= tag_t'(1);
            tail     <= tag_t'(1);
            count    <= '0;
            ent_busy <= '0;
            ent_done <= '0;
        end else begin
            if (wb_en)
                ent_done[wb_tag] <= 1'b1;
            if (issue_take) begin
                ent_busy[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail           <= next_tag(tail);
            end
            if (cm_en) begin
                ent_busy[head] <= 1'b0;
                head           <= next_tag(head);
            end
            count <= count + (TAG_W+1)'(issue_take) - (TAG_W+1)'(cm_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en)
            ent_data[wb_tag] <= wb_data;
        if (issue_take)
            ent_rd[tail] <= dec_rd;
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= ROB_DEPTH);

    // ALU result must land on a live, unfinished entry
    a_wb_live: assert property (@(posedge clk) disable iff (rst)
        wb_en |-> ent_busy[wb_tag] && !ent_done[wb_tag]);

endmodule

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ex_en,
    input  alu_op_t ex_op,
    input  data_t   ex_a,
    input  data_t   ex_b,
    input  tag_t    ex_tag,
    output logic    wb_en,
    output tag_t    wb_tag,
    output data_t   wb_data
);

    logic [4:0] shamt;
    data_t      result;

    assign shamt = ex_b[4:0];

    always_comb begin
        case (ex_op)
            ALU_ADD:  result = ex_a + ex_b;
            ALU_SUB:  result = ex_a - ex_b;
            ALU_SLL:  result = ex_a << shamt;
            ALU_SLT:  result = data_t'($signed(ex_a) < $signed(ex_b));
            ALU_SLTU: result = data_t'(ex_a < ex_b);
            ALU_XOR:  result = ex_a ^ ex_b;
            ALU_SRL:  result = ex_a >> shamt;
            ALU_SRA:  result = data_t'($signed(ex_a) >>> shamt);
            ALU_OR:   result = ex_a | ex_b;
            ALU_AND:  result = ex_a & ex_b;
            default:  result = ex_b;  // lui
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            wb_en <= 1'b0;
        else
            wb_en <= ex_en;
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            wb_tag  <= ex_tag;
            wb_data <= result;
        end
    end

endmodule

// ==== hdl/tag_regfile.sv ====
`timescale 1ns/1ps

module tag_regfile
    import rename_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  regnm_t rs1,
    input  regnm_t rs2,
    output data_t  rs1_data,
    output data_t  rs2_data,
    output tag_t   rs1_tag,
    output tag_t   rs2_tag,
    input  logic   alloc_en,
    input  regnm_t alloc_rd,
    input  tag_t   alloc_tag,
    input  logic   cm_en,
    input  regnm_t cm_rd,
    input  tag_t   cm_tag,
    input  data_t  cm_data
);

    data_t reg_data [REG_NUM];
    tag_t  reg_tag  [REG_NUM];

    // x0 is hardwired
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
            rs1_tag  = TAG_NONE;
        end else begin
            rs1_data = reg_data[rs1];
            rs1_tag  = reg_tag[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
            rs2_tag  = TAG_NONE;
        end else begin
            rs2_data = reg_data[rs2];
            rs2_tag  = reg_tag[rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_data[i] <= '0;
                reg_tag[i]  <= TAG_NONE;
            end
        end else begin
            // a younger rename keeps its tag
            if (cm_en && reg_tag[cm_rd] == cm_tag) begin
                reg_data[cm_rd] <= cm_data;
                reg_tag[cm_rd]  <= TAG_NONE;
            end
            if (alloc_en)
                reg_tag[alloc_rd] <= alloc_tag;  // last assignment wins on the same rd
        end
    end

    // decoder drops x0 writers, buffer hands out tags 1..7
    a_alloc_rd: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> alloc_rd != '0);

    a_alloc_tag: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> alloc_tag != TAG_NONE);

endmodule

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_req,
    input  inst_t   inst,
    output logic    inst_ack,
    input  logic    issue_take,
    output logic    dec_valid,
    output regnm_t  dec_rd,
    output regnm_t  dec_rs1,
    output regnm_t  dec_rs2,
    output logic    dec_use_rs2,
    output data_t   dec_imm,
    output alu_op_t dec_op
);

    hs_state_t  state;
    logic [6:0] opcode;
    regnm_t     rd_field;
    logic       known;
    logic       take_word;
    alu_op_t    op_next;
    data_t      imm_next;

    // funct3 map shared by register and immediate forms
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;  // addi has no sub
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = inst[6:0];
    assign rd_field  = inst[11:7];
    assign take_word = (state == HS_IDLE) && inst_req && (!dec_valid || issue_take);

    always_comb begin
        known    = 1'b1;
        op_next  = alu_sel(inst[14:12], inst[30], opcode == OP_REG);
        imm_next = {{20{inst[31]}}, inst[31:20]};  // I-type
        case (opcode)
            OP_REG, OP_IMM: ;
            OP_LUI: begin
                op_next  = ALU_LUI;
                imm_next = {inst[31:12], 12'b0};
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= HS_IDLE;
            inst_ack  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            if (issue_take)
                dec_valid <= 1'b0;
            case (state)
                HS_IDLE: begin
                    if (take_word) begin
                        inst_ack  <= 1'b1;
                        dec_valid <= known && (rd_field != '0);  // drop no-effect words
                        state     <= HS_HOLD;
                    end
                end
                HS_HOLD: begin
                    if (!inst_req) begin
                        inst_ack <= 1'b0;
                        state    <= HS_RELEASE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_word) begin
            dec_rd      <= rd_field;
            dec_rs1     <= (opcode == OP_LUI) ? regnm_t'(0) : inst[19:15];  // imm bits in lui
            dec_rs2     <= inst[24:20];
            dec_use_rs2 <= (opcode == OP_REG);
            dec_imm     <= imm_next;
            dec_op      <= op_next;
        end
    end

    a_dec_held: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !issue_take |=> dec_valid);

endmodule

// ==== hdl/rename_pkg.sv ====
package rename_pkg;

    // sizes fixed by the RV32I ISA
    localparam int XLEN      = 32;
    localparam int REG_NUM   = 32;
    localparam int ROB_DEPTH = 7;    // tags 1..7
    localparam int TAG_W     = 3;

    typedef logic [XLEN-1:0]            data_t;
    typedef logic [$clog2(REG_NUM)-1:0] regnm_t;
    typedef logic [TAG_W-1:0]           tag_t;
    typedef logic [31:0]                inst_t;

    localparam tag_t TAG_NONE = '0;  // register value is current

    // major opcodes of the integer ALU group
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI     // pass operand b
    } alu_op_t;

    // four-phase port, decoder side
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_HOLD,
        HS_RELEASE
    } hs_state_t;

endpackage
